//--- hdl/opdec_params.svh
`ifndef OPDEC_PARAMS_SVH
`define OPDEC_PARAMS_SVH

// microcode entry address width
`define SEQ_ADDR_WIDTH 8

// register numbers
`define REG_W    4
`define REG_AX   4'd0
`define REG_BX   4'd3
`define REG_BP   4'd5
`define REG_SI   4'd6
`define REG_DI   4'd7
`define REG_NONE 4'd12

// form offsets inside a microcode block
`define FORM_RRB 8'd0
`define FORM_RRW 8'd1
`define FORM_RMB 8'd2
`define FORM_RMW 8'd3
`define FORM_MRB 8'd4
`define FORM_MRW 8'd5
`define FORM_IRB 8'd6
`define FORM_IRW 8'd7
`define FORM_IMB 8'd8
`define FORM_IMW 8'd9

// alu blocks, one per operation code
`define ALU_BASE   8'd0
`define ALU_STRIDE 8'd16

`define MOV_BASE 8'd128

// single entries
`define SEQ_INCRW 8'd160
`define SEQ_DECRW 8'd161
`define SEQ_PUSHR 8'd162
`define SEQ_POPR  8'd163
`define SEQ_HLT   8'd164

`endif

//--- hdl/opdec_pkg.sv
`default_nettype none

package opdec_pkg;

        // one opcode byte, two ways of slicing it
        typedef union packed {
                struct packed {
                        logic [1:0] op_class;   // 00 alu, 10 mov and group
                        logic [2:0] alu_op;     // add or adc sbb and sub xor cmp
                        logic       acc_imm;    // accumulator immediate
                        logic       dir;        // reg field is destination
                        logic       wide;       // word operand
                } alu_form;
                struct packed {
                        logic [4:0] group;
                        logic [2:0] reg_num;    // register in low bits
                } short_form;
        } opcode_u;

endpackage

`default_nettype wire

//--- hdl/ea_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "opdec_params.svh"

module ea_decoder
(
        input  logic [7:0]        modrm,
        output logic [`REG_W-1:0] base,
        output logic [`REG_W-1:0] index,
        output logic              mem_disp,
        output logic              disp_word
);

        logic [1:0] mod;
        logic [2:0] rm;
        logic       direct;

        assign mod    = modrm[7:6];
        assign rm     = modrm[2:0];
        assign direct = (mod == 2'b00) && (rm == 3'b110);    // [disp16]

        always_comb
        begin
                case (rm)
                        3'b000, 3'b001, 3'b111: base = `REG_BX;
                        3'b010, 3'b011:         base = `REG_BP;
                        3'b110:                 base = direct ? `REG_NONE : `REG_BP;
                        default:                base = `REG_NONE;
                endcase

                case (rm)
                        3'b000, 3'b010, 3'b100: index = `REG_SI;
                        3'b001, 3'b011, 3'b101: index = `REG_DI;
                        default:                index = `REG_NONE;
                endcase

                // register operand, no address at all
                if (mod == 2'b11)
                begin
                        base  = `REG_NONE;
                        index = `REG_NONE;
                end
        end

        assign mem_disp  = (^mod) | direct;                  // mod 01 or 10
        assign disp_word = (mod == 2'b10) | direct;

endmodule

`default_nettype wire

//--- hdl/alu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "opdec_params.svh"

module alu_decoder
        import opdec_pkg::*;
(
        input  opcode_u                    op,
        input  logic [7:0]                 modrm,
        output logic                       hit,
        output logic [`SEQ_ADDR_WIDTH-1:0] seq_addr,
        output logic                       uses_modrm,
        output logic                       need_imm,
        output logic                       imm_size,
        output logic [`REG_W-1:0]          src,
        output logic [`REG_W-1:0]          dst
);

        logic [1:0]                 mod;
        logic [2:0]                 reg_f;
        logic [2:0]                 rm;
        logic                       wide;
        logic                       dir;
        logic                       reg_mem;
        logic                       acc_form;
        logic                       grp_form;
        logic [2:0]                 alu_sel;
        logic [`SEQ_ADDR_WIDTH-1:0] form;

        assign mod   = modrm[7:6];
        assign reg_f = modrm[5:3];
        assign rm    = modrm[2:0];
        assign wide  = op.alu_form.wide;
        assign dir   = op.alu_form.dir;

        // 00-3f, low bits 0-3
        assign reg_mem  = (op.alu_form.op_class == 2'b00) && !op.alu_form.acc_imm;
        // 00-3f, low bits 4-5
        assign acc_form = (op.alu_form.op_class == 2'b00) && op.alu_form.acc_imm && !dir;
        // 80-83
        assign grp_form = (op.alu_form.op_class == 2'b10) && (op.alu_form.alu_op == 3'b000)
                          && !op.alu_form.acc_imm;

        assign hit     = reg_mem | acc_form | grp_form;
        assign alu_sel = grp_form ? reg_f : op.alu_form.alu_op;   // group op in reg field

        assign seq_addr = `ALU_BASE + `SEQ_ADDR_WIDTH'(alu_sel) * `ALU_STRIDE + form;

        always_comb
        begin
                form       = `FORM_RRB;
                uses_modrm = 1'b0;
                need_imm   = 1'b0;
                imm_size   = 1'b0;
                src        = '0;
                dst        = '0;
                if (reg_mem)
                begin
                        uses_modrm = 1'b1;
                        if (mod == 2'b11)
                                form = wide ? `FORM_RRW : `FORM_RRB;
                        else if (dir)
                                form = wide ? `FORM_MRW : `FORM_MRB;
                        else
                                form = wide ? `FORM_RMW : `FORM_RMB;
                        dst = `REG_W'(dir ? reg_f : rm);
                        src = `REG_W'(dir ? rm : reg_f);
                end
                else if (acc_form)
                begin
                        form     = wide ? `FORM_IRW : `FORM_IRB;
                        need_imm = 1'b1;
                        imm_size = wide;
                        src      = `REG_AX;                      // al or ax implied
                        dst      = `REG_AX;
                end
                else if (grp_form)
                begin
                        uses_modrm = 1'b1;
                        if (mod == 2'b11)
                                form = wide ? `FORM_IRW : `FORM_IRB;
                        else
                                form = wide ? `FORM_IMW : `FORM_IMB;
                        need_imm = 1'b1;
                        imm_size = wide & !dir;                  // 83 sign extends imm8
                        dst      = `REG_W'(rm);
                end
        end

endmodule

`default_nettype wire

//--- hdl/mov_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "opdec_params.svh"

module mov_decoder
        import opdec_pkg::*;
(
        input  opcode_u                    op,
        input  logic [7:0]                 modrm,
        output logic                       hit,
        output logic [`SEQ_ADDR_WIDTH-1:0] seq_addr,
        output logic                       uses_modrm,
        output logic                       need_imm,
        output logic                       imm_size,
        output logic [`REG_W-1:0]          src,
        output logic [`REG_W-1:0]          dst
);

        logic [1:0]                 mod;
        logic [2:0]                 reg_f;
        logic [2:0]                 rm;
        logic                       wide;
        logic                       dir;
        logic                       rm_form;
        logic                       imm_form;
        logic [`SEQ_ADDR_WIDTH-1:0] form;

        assign mod   = modrm[7:6];
        assign reg_f = modrm[5:3];
        assign rm    = modrm[2:0];
        assign wide  = op.alu_form.wide;
        assign dir   = op.alu_form.dir;

        assign rm_form  = (op.alu_form.op_class == 2'b10) && (op.alu_form.alu_op == 3'b001)
                          && !op.alu_form.acc_imm;                      // 88-8b
        assign imm_form = (op.alu_form.op_class == 2'b10) && (op.alu_form.alu_op[2:1] == 2'b11);

        assign hit      = rm_form | imm_form;
        assign seq_addr = `MOV_BASE + form;

        always_comb
        begin
                form       = `FORM_RRB;
                uses_modrm = 1'b0;
                need_imm   = 1'b0;
                imm_size   = 1'b0;
                src        = '0;
                dst        = '0;
                if (rm_form)
                begin
                        uses_modrm = 1'b1;
                        if (mod == 2'b11)
                        begin
                                form = wide ? `FORM_RRW : `FORM_RRB;
                                dst  = `REG_W'(dir ? reg_f : rm);
                                src  = `REG_W'(dir ? rm : reg_f);
                        end
                        else if (dir)
                        begin
                                form = wide ? `FORM_MRW : `FORM_MRB;
                                dst  = `REG_W'(reg_f);
                        end
                        else
                        begin
                                form = wide ? `FORM_RMW : `FORM_RMB;
                                src  = `REG_W'(reg_f);
                        end
                end
                else if (imm_form)
                begin
                        form     = op[3] ? `FORM_IRW : `FORM_IRB;   // bit 3 picks word
                        need_imm = 1'b1;
                        imm_size = op[3];
                        dst      = `REG_W'(op[2:0]);
                end
        end

endmodule

`default_nettype wire

//--- hdl/opcode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "opdec_params.svh"

module opcode_decoder
        import opdec_pkg::*;
(
        input  logic                       clk,
        input  logic                       rst_n,
        input  logic                       op_valid,
        input  logic [7:0]                 op,
        input  logic [7:0]                 modrm,
        output logic                       dec_valid,
        output logic [`SEQ_ADDR_WIDTH-1:0] seq_addr,
        output logic                       need_modrm,
        output logic                       need_off,
        output logic                       off_size,
        output logic                       need_imm,
        output logic                       imm_size,
        output logic [`REG_W-1:0]          src,
        output logic [`REG_W-1:0]          dst,
        output logic [`REG_W-1:0]          base,
        output logic [`REG_W-1:0]          index
);

        opcode_u                    op_u;
        logic [`REG_W-1:0]          ea_base;
        logic [`REG_W-1:0]          ea_index;
        logic                       ea_disp;
        logic                       ea_disp_w;
        logic                       alu_hit;
        logic [`SEQ_ADDR_WIDTH-1:0] alu_addr;
        logic                       alu_modrm;
        logic                       alu_imm;
        logic                       alu_isize;
        logic [`REG_W-1:0]          alu_src;
        logic [`REG_W-1:0]          alu_dst;
        logic                       mov_hit;
        logic [`SEQ_ADDR_WIDTH-1:0] mov_addr;
        logic                       mov_modrm;
        logic                       mov_imm;
        logic                       mov_isize;
        logic [`REG_W-1:0]          mov_src;
        logic [`REG_W-1:0]          mov_dst;
        logic                       nxt_hit;
        logic [`SEQ_ADDR_WIDTH-1:0] nxt_addr;
        logic                       nxt_modrm;
        logic                       nxt_off;
        logic                       nxt_osize;
        logic                       nxt_imm;
        logic                       nxt_isize;
        logic [`REG_W-1:0]          nxt_src;
        logic [`REG_W-1:0]          nxt_dst;
        logic [`REG_W-1:0]          nxt_base;
        logic [`REG_W-1:0]          nxt_index;
        logic [`REG_W-1:0]          short_reg;

        assign op_u      = op;
        assign short_reg = `REG_W'(op_u.short_form.reg_num);

        ea_decoder i_ea
        (
                .modrm     (modrm),
                .base      (ea_base),
                .index     (ea_index),
                .mem_disp  (ea_disp),
                .disp_word (ea_disp_w)
        );

        alu_decoder i_alu
        (
                .op         (op_u),
                .modrm      (modrm),
                .hit        (alu_hit),
                .seq_addr   (alu_addr),
                .uses_modrm (alu_modrm),
                .need_imm   (alu_imm),
                .imm_size   (alu_isize),
                .src        (alu_src),
                .dst        (alu_dst)
        );

        mov_decoder i_mov
        (
                .op         (op_u),
                .modrm      (modrm),
                .hit        (mov_hit),
                .seq_addr   (mov_addr),
                .uses_modrm (mov_modrm),
                .need_imm   (mov_imm),
                .imm_size   (mov_isize),
                .src        (mov_src),
                .dst        (mov_dst)
        );

        always_comb
        begin
                nxt_hit   = 1'b1;
                nxt_addr  = `SEQ_HLT;
                nxt_modrm = 1'b0;
                nxt_imm   = 1'b0;
                nxt_isize = 1'b0;
                nxt_src   = '0;
                nxt_dst   = '0;
                if (alu_hit)
                begin
                        nxt_addr  = alu_addr;
                        nxt_modrm = alu_modrm;
                        nxt_imm   = alu_imm;
                        nxt_isize = alu_isize;
                        nxt_src   = alu_src;
                        nxt_dst   = alu_dst;
                end
                else if (mov_hit)
                begin
                        nxt_addr  = mov_addr;
                        nxt_modrm = mov_modrm;
                        nxt_imm   = mov_imm;
                        nxt_isize = mov_isize;
                        nxt_src   = mov_src;
                        nxt_dst   = mov_dst;
                end
                else
                begin
                        case (op_u.short_form.group)
                                5'b01000:                        // inc 40-47
                                begin
                                        nxt_addr = `SEQ_INCRW;
                                        nxt_src  = short_reg;
                                end
                                5'b01001:                        // dec 48-4f
                                begin
                                        nxt_addr = `SEQ_DECRW;
                                        nxt_src  = short_reg;
                                end
                                5'b01010:                        // push 50-57
                                begin
                                        nxt_addr = `SEQ_PUSHR;
                                        nxt_src  = short_reg;
                                end
                                5'b01011:                        // pop 58-5f
                                begin
                                        nxt_addr = `SEQ_POPR;
                                        nxt_dst  = short_reg;
                                end
                                default:
                                        nxt_hit  = 1'b0;         // falls to hlt
                        endcase
                end
        end

        // address registers only mean something with a modrm byte
        assign nxt_base  = nxt_modrm ? ea_base : (nxt_hit ? `REG_NONE : '0);
        assign nxt_index = nxt_modrm ? ea_index : (nxt_hit ? `REG_NONE : '0);
        assign nxt_off   = nxt_modrm & ea_disp;
        assign nxt_osize = nxt_off & ea_disp_w;

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        dec_valid  <= 1'b0;
                        seq_addr   <= '0;
                        need_modrm <= 1'b0;
                        need_off   <= 1'b0;
                        off_size   <= 1'b0;
                        need_imm   <= 1'b0;
                        imm_size   <= 1'b0;
                        src        <= '0;
                        dst        <= '0;
                        base       <= '0;
                        index      <= '0;
                end
                else
                begin
                        dec_valid <= op_valid;
                        if (op_valid)                            // hold last decode otherwise
                        begin
                                seq_addr   <= nxt_addr;
                                need_modrm <= nxt_modrm;
                                need_off   <= nxt_off;
                                off_size   <= nxt_osize;
                                need_imm   <= nxt_imm;
                                imm_size   <= nxt_isize;
                                src        <= nxt_src;
                                dst        <= nxt_dst;
                                base       <= nxt_base;
                                index      <= nxt_index;
                        end
                end
        end

endmodule

`default_nettype wire

//--- sim/opdec_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module opdec_asserts
(
        input logic clk,
        input logic rst_n,
        input logic op_valid,
        input logic dec_valid,
        input logic need_modrm,
        input logic need_off,
        input logic off_size
);

        // a displacement is only fetched behind a modrm byte
        property off_needs_modrm;
                @(posedge clk) disable iff (!rst_n)
                need_off |-> need_modrm;
        endproperty

        property size_needs_off;
                @(posedge clk) disable iff (!rst_n)
                off_size |-> need_off;
        endproperty

        // one cycle of latency, no stall
        property valid_follows;
                @(posedge clk) disable iff (!rst_n)
                dec_valid == $past(op_valid);
        endproperty

        a_off_needs_modrm : assert property (off_needs_modrm)
                else $error("need_off set while need_modrm is clear");

        a_size_needs_off : assert property (size_needs_off)
                else $error("off_size set while need_off is clear");

        a_valid_follows : assert property (valid_follows)
                else $error("dec_valid does not follow op_valid by one cycle");

endmodule

`default_nettype wire

//--- sim/tb_opcode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "opdec_params.svh"

module tb_opcode_decoder;

        localparam int SEED        = 84779;
        localparam int CYCLE_LIMIT = 3000;      // tests take about 650 cycles

        logic                       clk = 1'b0;
        logic                       rst_n;
        logic                       op_valid;
        logic [7:0]                 op;
        logic [7:0]                 modrm;
        logic                       dec_valid;
        logic [`SEQ_ADDR_WIDTH-1:0] seq_addr;
        logic                       need_modrm;
        logic                       need_off;
        logic                       off_size;
        logic                       need_imm;
        logic                       imm_size;
        logic [`REG_W-1:0]          src;
        logic [`REG_W-1:0]          dst;
        logic [`REG_W-1:0]          base;
        logic [`REG_W-1:0]          index;
        logic [28:0]                dut_res;
        logic [28:0]                exp_res;    // last valid decode, held
        logic                       exp_valid;
        logic [7:0]                 exp_op;
        logic [7:0]                 exp_modrm;
        logic                       pend;       // a pair waits for its result
        int                         cycles = 0;
        int                         errors;
        int                         checks;
        int                         test_errors;
        string                      test_name;

        opcode_decoder i_dut
        (
                .clk        (clk),
                .rst_n      (rst_n),
                .op_valid   (op_valid),
                .op         (op),
                .modrm      (modrm),
                .dec_valid  (dec_valid),
                .seq_addr   (seq_addr),
                .need_modrm (need_modrm),
                .need_off   (need_off),
                .off_size   (off_size),
                .need_imm   (need_imm),
                .imm_size   (imm_size),
                .src        (src),
                .dst        (dst),
                .base       (base),
                .index      (index)
        );

        bind opcode_decoder opdec_asserts i_asserts
        (
                .clk        (clk),
                .rst_n      (rst_n),
                .op_valid   (op_valid),
                .dec_valid  (dec_valid),
                .need_modrm (need_modrm),
                .need_off   (need_off),
                .off_size   (off_size)
        );

        assign dut_res = {seq_addr, need_modrm, need_off, off_size, need_imm, imm_size,
                          src, dst, base, index};

        always #50 clk = ~clk;

        always @(posedge clk)
        begin
                cycles = cycles + 1;
                if (cycles >= CYCLE_LIMIT)
                begin
                        $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
                        $display("TEST FAIL");
                        $finish;
                end
        end

        function automatic logic [7:0] alu_entry(input logic [2:0] n, input logic [7:0] fo);
                return `ALU_BASE + {5'd0, n} * `ALU_STRIDE + fo;
        endfunction

        // expected outputs as {addr, modrm, off, osize, imm, isize, src, dst, base, index}
        function automatic logic [28:0] decode_ref(input logic [7:0] opc, input logic [7:0] mrm);
                logic [7:0] addr;
                logic [7:0] ea;
                logic [1:0] md;
                logic [2:0] rg;
                logic [2:0] rm;
                logic       hit;
                logic       uses;
                logic       imm;
                logic       isize;
                logic       direct;
                logic       off;
                logic [3:0] s;
                logic [3:0] t;
                md     = mrm[7:6];
                rg     = mrm[5:3];
                rm     = mrm[2:0];
                direct = (md == 2'b00) && (rm == 3'd6);
                addr   = `SEQ_HLT;
                {hit, uses, imm, isize, s, t} = '0;
                if (opc < 8'h40 && !opc[2])
                begin
                        {hit, uses} = 2'b11;
                        addr = alu_entry(opc[5:3], (md == 2'b11) ? {7'd0, opc[0]} :
                                         opc[1] ? `FORM_MRB + opc[0] : `FORM_RMB + opc[0]);
                        t = {1'b0, opc[1] ? rg : rm};
                        s = {1'b0, opc[1] ? rm : rg};
                end
                else if (opc < 8'h40 && opc[2:1] == 2'b10)
                begin
                        {hit, imm, isize} = {2'b11, opc[0]};
                        addr = alu_entry(opc[5:3], `FORM_IRB + opc[0]);
                end
                else if (opc >= 8'h80 && opc <= 8'h83)
                begin
                        {hit, uses, imm, isize} = {3'b111, opc == 8'h81};
                        addr = alu_entry(rg, ((md == 2'b11) ? `FORM_IRB : `FORM_IMB) + opc[0]);
                        t = {1'b0, rm};
                end
                else if (opc >= 8'h88 && opc <= 8'h8B)
                begin
                        {hit, uses} = 2'b11;
                        if (md == 2'b11)
                        begin
                                addr = `MOV_BASE + `FORM_RRB + opc[0];
                                t = {1'b0, opc[1] ? rg : rm};
                                s = {1'b0, opc[1] ? rm : rg};
                        end
                        else
                        begin
                                addr = `MOV_BASE + (opc[1] ? `FORM_MRB : `FORM_RMB) + opc[0];
                                t = opc[1] ? {1'b0, rg} : 4'd0;
                                s = opc[1] ? 4'd0 : {1'b0, rg};
                        end
                end
                else if (opc >= 8'hB0)
                begin
                        {hit, imm, isize} = {2'b11, opc[3]};
                        addr = `MOV_BASE + `FORM_IRB + opc[3];
                        t = {1'b0, opc[2:0]};
                end
                else if (opc >= 8'h40 && opc <= 8'h5F)
                begin
                        hit = 1'b1;
                        addr = `SEQ_INCRW + opc[4:3];   // inc dec push pop in order
                        if (opc[4:3] == 2'b11)
                                t = {1'b0, opc[2:0]};
                        else
                                s = {1'b0, opc[2:0]};
                end
                if (opc >= 8'hC0)
                        {hit, imm, isize, t, addr} = {3'b000, 4'd0, `SEQ_HLT};
                case (rm)                        // {base, index}
                        3'd0: ea = {`REG_BX, `REG_SI};
                        3'd1: ea = {`REG_BX, `REG_DI};
                        3'd2: ea = {`REG_BP, `REG_SI};
                        3'd3: ea = {`REG_BP, `REG_DI};
                        3'd4: ea = {`REG_NONE, `REG_SI};
                        3'd5: ea = {`REG_NONE, `REG_DI};
                        3'd6: ea = {direct ? `REG_NONE : `REG_BP, `REG_NONE};
                        default: ea = {`REG_BX, `REG_NONE};
                endcase
                if (md == 2'b11)
                        ea = {`REG_NONE, `REG_NONE};
                if (!uses)
                        ea = hit ? {`REG_NONE, `REG_NONE} : 8'd0;
                off = uses && (md == 2'b01 || md == 2'b10 || direct);
                return {addr, uses, off, off && (md == 2'b10 || direct), imm, isize, s, t, ea};
        endfunction

        task automatic check_result();
                checks++;
                assert (dec_valid === exp_valid)
                else
                begin
                        $display("FAIL %0t: %s dec_valid is %b, expected %b", $time, test_name,
                                 dec_valid, exp_valid);
                        errors++;
                        test_errors++;
                end
                assert (dut_res === exp_res)
                else
                begin
                        $display("FAIL %0t: %s op %h modrm %h gave %h, expected %h", $time,
                                 test_name, exp_op, exp_modrm, dut_res, exp_res);
                        errors++;
                        test_errors++;
                end
        endtask

        // one pair per falling edge, result of the previous pair checked first
        task automatic drive_pair(input logic v, input logic [7:0] opc, input logic [7:0] mrm);
                @(negedge clk);
                if (pend)
                        check_result();
                op_valid  = v;
                op        = opc;
                modrm     = mrm;
                exp_valid = v;
                pend      = 1'b1;
                if (v)
                begin
                        exp_res   = decode_ref(opc, mrm);
                        exp_op    = opc;
                        exp_modrm = mrm;
                end
        endtask

        task automatic end_test();
                drive_pair(1'b0, 8'h00, 8'h00);
                @(negedge clk);
                check_result();
                pend = 1'b0;
                $display("%s finished with %0d errors", test_name, test_errors);
        endtask

        task automatic start_test(input string name);
                test_name   = name;
                test_errors = 0;
        endtask

        task automatic reset_state();
                start_test("reset");
                check_result();
                repeat (3)
                        drive_pair(1'b0, 8'h00, 8'h00);
                end_test();
        endtask

        task automatic alu_reg_mem();
                logic [31:0] r;
                start_test("alu reg/mem");
                for (int i = 0; i < 64; i++)
                        for (int m = 0; m < 4 && i[2:1] != 2'b11; m++)
                        begin
                                r = $urandom;
                                drive_pair(1'b1, i[7:0], {m[1:0], r[5:0]});
                        end
                end_test();
        endtask

        task automatic alu_immediate();
                logic [31:0] r;
                start_test("alu immediate");
                for (int i = 0; i < 16; i++)
                begin
                        r = $urandom;
                        drive_pair(1'b1, {2'b00, i[3:1], 2'b10, i[0]}, r[7:0]);
                end
                for (int i = 0; i < 128; i++)
                begin
                        r = $urandom;
                        drive_pair(1'b1, 8'h80 + {6'd0, i[1:0]}, {i[6:5], i[4:2], r[2:0]});
                end
                end_test();
        endtask

        task automatic mov_and_short();
                logic [31:0] r;
                start_test("mov and short forms");
                for (int i = 0; i < 32; i++)
                begin
                        r = $urandom;
                        drive_pair(1'b1, 8'h88 + {6'd0, i[1:0]}, {i[3:2], r[5:0]});
                end
                for (int i = 0; i < 48; i++)
                begin
                        r = $urandom;
                        drive_pair(1'b1, (i < 16) ? 8'hB0 + i[7:0] : 8'h30 + i[7:0], r[7:0]);
                end
                end_test();
        endtask

        task automatic back_to_back();
                logic [7:0]  picks [8] = '{8'hF4, 8'h9C, 8'h06, 8'h27, 8'h8D, 8'h01, 8'h83, 8'hB7};
                logic [31:0] r;
                start_test("back to back");
                for (int i = 0; i < 200; i++)
                begin
                        r = $urandom;
                        drive_pair(r[0], r[4] ? r[15:8] : picks[r[7:5]], r[23:16]);
                end
                end_test();
        endtask

        initial
        begin
                void'($urandom(SEED));
                rst_n     = 1'b0;
                op_valid  = 1'b0;
                op        = 8'h00;
                modrm     = 8'h00;
                pend      = 1'b0;
                exp_valid = 1'b0;
                exp_res   = '0;
                exp_op    = 8'h00;
                exp_modrm = 8'h00;
                errors    = 0;
                checks    = 0;
                repeat (16)
                        @(negedge clk);
                rst_n = 1'b1;
                reset_state();
                alu_reg_mem();
                alu_immediate();
                mov_and_short();
                back_to_back();
                $display("%0d checks, %0d errors", checks, errors);
                if (errors == 0)
                        $display("TEST PASS");
                else
                        $display("TEST FAIL");
                $finish;
        end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/opdec_pkg.sv
hdl/ea_decoder.sv
hdl/alu_decoder.sv
hdl/mov_decoder.sv
hdl/opcode_decoder.sv
sim/opdec_asserts.sv
sim/tb_opcode_decoder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the opcode decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_opcode_decoder \
        -Mdir "$BUILD_DIR" -o tb_opcode_decoder
if [ $? -ne 0 ]; then
        echo "compile failed"
        exit 1
fi

"./$BUILD_DIR/tb_opcode_decoder" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
        echo "simulation exited with status $sim_status"
        exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
        echo "simulation passed"
        exit 0
fi
echo "simulation failed, see $LOG"
exit 1
